// ==== Makefile ====
BIN := obj_dir/Vtag_core_tb

$(BIN): tb.f $(filter %.sv,$(shell cat tb.f)) $(wildcard rtl/*.svh)
	verilator --binary --timing --assert -f tb.f --top-module tag_core_tb -Mdir obj_dir

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== bench/tag_core_tb.sv ====
// expects two lanes, eight 3-bit tags and 8-bit data; runs one fixed-seed sequence, then stops
`timescale 1ns/1ps
`default_nettype none

`include "tag_settings.svh"

module tag_core_tb;

  localparam int STALL_LIMIT = 20;
  localparam int DRAIN_LIMIT = 40;

  logic                              clk;
  logic                              rst;
  logic                              flush;
  logic [`LANES-1:0]                 in_valid;
  logic [`LANES-1:0][`INSN_W-1:0]    in_insn;
  logic                              stall;
  logic [`LANES-1:0]                 done_valid;
  logic [`LANES-1:0][`TAG_W-1:0]     done_tag;
  logic [`LANES-1:0][`DATA_W-1:0]    done_value;
  logic [`LANES-1:0]                 done_zero;
  logic [`LANES-1:0]                 done_neg;

  logic [15:0]           lfsr_state;
  int unsigned           cyc;
  int                    checks;
  int                    errors;
  int                    timeouts;

  // free set as the lowest-first rule predicts it
  logic [`TAG_COUNT-1:0] used_model;
  logic                  stall_model;
  // per lane: {due cycle, tag, neg, zero, value}
  logic [44:0]           exp_q [`LANES][$];

  tag_core DUT (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_insn    (in_insn),
    .flush      (flush),
    .stall      (stall),
    .done_valid (done_valid),
    .done_tag   (done_tag),
    .done_value (done_value),
    .done_zero  (done_zero),
    .done_neg   (done_neg)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // roughly one word in eight is a nop
  function logic [`INSN_W-1:0] make_word(input logic force_nop);
    logic [2:0]  op;
    logic [16:0] body;
    op = 3'(rand_bits(2));
    if (rand_bits(3) == 32'd0 || force_nop) begin
      op = 3'd7;
    end
    body = 17'(rand_bits(17));
    return {op, body};
  endfunction

  // {neg, zero, value} for one instruction word
  function automatic logic [9:0] ref_result(input logic [`INSN_W-1:0] w);
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] r;
    a = w[15:8];
    if (w[16]) begin
      b = {2'b00, w[5:0]} << w[7:6];
    end else begin
      b = w[7:0];
    end
    case (w[19:17])
      3'd0:    r = a + b;
      3'd1:    r = a - b;
      3'd2:    r = a & b;
      3'd3:    r = a ^ b;
      default: r = 8'd0;
    endcase
    return {r[7], r == 8'd0, r};
  endfunction

  // rank-th lowest tag not in flight
  function automatic logic [`TAG_W-1:0] nth_free(input logic [`TAG_COUNT-1:0] used,
                                                 input int rank);
    int left;
    int t;
    left = rank;
    t = 0;
    while (t < `TAG_COUNT - 1 && (used[t] || left > 0)) begin
      if (!used[t]) begin
        left--;
      end
      t++;
    end
    return `TAG_W'(t);
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // group stays on the inputs until an edge with stall low
  task automatic send_group(input logic [1:0] mask, input logic all_nop);
    int waited;
    in_valid   = mask;
    in_insn[0] = make_word(all_nop);
    in_insn[1] = make_word(all_nop);
    waited = 0;
    @(negedge clk);
    while (stall !== 1'b0 && waited < STALL_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (stall !== 1'b0) begin
      timeouts++;
      $display("timeout: stall stayed high for %0d cycles at %0t", STALL_LIMIT, $time);
    end
    @(posedge clk);
    #1;
    in_valid = '0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
    end
    #1;
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_q[0].size() != 0 || exp_q[1].size() != 0) && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      timeouts++;
      $display("timeout: results still outstanding after %0d cycles", DRAIN_LIMIT);
    end
  endtask

  // everything sampled mid-cycle, between drive and the next edge
  always @(negedge clk) begin : monitor
    logic [`TAG_COUNT-1:0] collect;
    logic [`TAG_COUNT-1:0] alloc;
    logic [44:0]           ent;
    logic [`TAG_W-1:0]     tag;
    logic                  expect_v;
    int                    nfree;
    cyc++;
    if (rst) begin
      exp_q[0].delete();
      exp_q[1].delete();
      used_model  = '0;
      stall_model = 1'b0;
    end else begin
      check("stall", 32'(stall), 32'(stall_model));
      collect = '0;
      for (int i = 0; i < `LANES; i++) begin
        expect_v = 1'b0;
        ent = '0;
        if (exp_q[i].size() > 0) begin
          ent = exp_q[i][0];
          expect_v = (ent[44:13] == cyc);
        end
        check($sformatf("done_valid[%0d]", i), 32'(done_valid[i]), 32'(expect_v));
        if (expect_v) begin
          ent = exp_q[i].pop_front();
          check($sformatf("done_tag[%0d]", i), 32'(done_tag[i]), 32'(ent[12:10]));
          check($sformatf("done_value[%0d]", i), 32'(done_value[i]), 32'(ent[7:0]));
          check($sformatf("done_zero[%0d]", i), 32'(done_zero[i]), 32'(ent[8]));
          check($sformatf("done_neg[%0d]", i), 32'(done_neg[i]), 32'(ent[9]));
          collect[ent[12:10]] = 1'b1;
        end
      end
      if (flush) begin
        exp_q[0].delete();
        exp_q[1].delete();
        used_model  = '0;
        stall_model = 1'b0;
      end else begin
        // port i takes the i-th lowest free tag
        alloc = '0;
        for (int i = 0; i < `LANES; i++) begin
          if (in_valid[i] && !stall_model && in_insn[i][19:17] != 3'd7) begin
            tag = nth_free(used_model, i);
            alloc[tag] = 1'b1;
            exp_q[i].push_back({32'(cyc + 4), tag, ref_result(in_insn[i])});
          end
        end
        used_model = (used_model & ~collect) | alloc;
        nfree = 0;
        for (int t = 0; t < `TAG_COUNT; t++) begin
          if (!used_model[t]) begin
            nfree++;
          end
        end
        stall_model = (nfree < `LANES);
      end
    end
  end

  initial begin
    lfsr_state = 16'd34199;
    cyc      = 0;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    rst      = 1'b1;
    flush    = 1'b0;
    in_valid = '0;
    in_insn  = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // first full group, tags 0 and 1
    send_group(2'b11, 1'b0);
    for (int n = 0; n < 40; n++) begin
      send_group(2'(rand_bits(2)), 1'b0);
    end
    idle(3);
    // back to back until the free list runs dry
    for (int n = 0; n < 16; n++) begin
      send_group(2'b11, 1'b0);
    end
    // nop-only groups
    for (int n = 0; n < 8; n++) begin
      send_group(2'b11, 1'b1);
    end
    // flush with three groups in flight
    for (int n = 0; n < 3; n++) begin
      send_group(2'b11, 1'b0);
    end
    pulse_flush();
    idle(6);
    send_group(2'b11, 1'b0);
    for (int n = 0; n < 20; n++) begin
      send_group(2'(rand_bits(2)), 1'b0);
    end
    wait_drain();
    idle(2);

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/freelist.sv ====
// scalar tag indexes only; port i always offers the i-th lowest free tag, collected tags free next cycle
`timescale 1ns/1ps
`default_nettype none

`include "tag_settings.svh"

module freelist (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              flush,
  // collect side
  input  logic [`LANES-1:0]                 we,
  input  logic [`LANES-1:0][`TAG_W-1:0]     wd,
  // request side
  input  logic [`LANES-1:0]                 re,
  output logic [`LANES-1:0][`TAG_W-1:0]     rd,
  output logic [`LANES-1:0]                 v,
  // fewer than LANES tags free after this edge
  output logic                              empty
);

  localparam int LN    = `LANES;
  localparam int DEPTH = `TAG_COUNT;
  localparam int TW    = `TAG_W;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // one bit per tag, set while the tag is in flight
  logic [DEPTH-1:0] r_usage;
  logic [DEPTH-1:0] set_vec;
  logic [DEPTH-1:0] clr_vec;
  logic [DEPTH-1:0] next_usage;
  logic [CNT_W-1:0] free_cnt;
  logic             next_empty;

  // rank-th free tag counting from tag 0, msb is the found flag
  function automatic logic [TW:0] pick_free(input int rank, input logic [DEPTH-1:0] used);
    int               seen;
    logic             found;
    logic [TW-1:0]    tag;
    seen  = 0;
    found = 1'b0;
    tag   = '0;
    for (int t = 0; t < DEPTH; t++) begin
      if (!used[t] && !found) begin
        if (seen == rank) begin
          found = 1'b1;
          tag   = TW'(t);
        end
        seen++;
      end
    end
    return {found, tag};
  endfunction

  for (genvar p = 0; p < LN; p++) begin : g_port
    assign {v[p], rd[p]} = pick_free(p, r_usage);
  end

  // decode requests and returns into per-tag set and clear masks
  always_comb begin
    set_vec = '0;
    clr_vec = '0;
    for (int p = 0; p < LN; p++) begin
      if (re[p]) set_vec[rd[p]] = 1'b1;
      if (we[p]) clr_vec[wd[p]] = 1'b1;
    end
  end

  assign next_usage = set_vec | (r_usage & ~clr_vec);

  // free entries once this edge's update has landed
  always_comb begin
    free_cnt = '0;
    for (int t = 0; t < DEPTH; t++) begin
      free_cnt = free_cnt + CNT_W'(!next_usage[t]);
    end
  end

  assign next_empty = (free_cnt < CNT_W'(LN));

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      r_usage <= '0;
      empty   <= 1'b0;
    end else begin
      r_usage <= next_usage;
      empty   <= next_empty;
    end
  end

  for (genvar p = 0; p < LN; p++) begin : g_chk
    // result stage only returns tags that were handed out
    a_collect_in_use : assert property (
      @(posedge clk) disable iff (rst || flush) we[p] |-> r_usage[wd[p]]
    ) else $error("freelist: collected tag %0d is already free", wd[p]);

    // stall must keep every issued lane supplied with a tag
    a_request_served : assert property (
      @(posedge clk) disable iff (rst || flush) re[p] |-> v[p]
    ) else $error("freelist: port %0d requested with no free tag", p);
  end

endmodule

`default_nettype wire

// ==== rtl/op_decode.sv ====
// purely combinational; relies on stall to guarantee tags, nop lanes are dropped here
`timescale 1ns/1ps
`default_nettype none

`include "tag_settings.svh"

module op_decode (
  input  logic [`LANES-1:0]                 in_valid,
  input  logic [`LANES-1:0][`INSN_W-1:0]    in_insn,
  input  logic                              stall,
  output logic [`LANES-1:0]                 re,
  output logic [`LANES-1:0]                 issue_valid,
  output tag_pkg::op_e [`LANES-1:0]         issue_op,
  output logic [`LANES-1:0][`DATA_W-1:0]    issue_a,
  output logic [`LANES-1:0][`DATA_W-1:0]    issue_b
);

  import tag_pkg::*;

  localparam int LN = `LANES;
  localparam int DW = `DATA_W;

  insn_u view [LN];

  always_comb begin
    for (int i = 0; i < LN; i++) begin
      view[i] = in_insn[i];

      // both formats share opcode, fmt and a
      issue_op[i] = view[i].as_reg.opcode;
      issue_a[i]  = view[i].as_reg.a;

      if (view[i].as_reg.fmt) begin
        // immediate, upper bits shifted out are lost
        issue_b[i] = DW'(view[i].as_imm.imm) << view[i].as_imm.shift;
      end else begin
        issue_b[i] = view[i].as_reg.b;
      end

      issue_valid[i] = in_valid[i] && !stall && (view[i].as_reg.opcode != op_nop);

      // every issued op takes a destination tag
      re[i] = issue_valid[i];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/op_execute.sv ====
// fixed three-stage pipe, no back-pressure; reserved opcodes produce zero
`timescale 1ns/1ps
`default_nettype none

`include "tag_settings.svh"

module op_execute (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              flush,
  input  logic [`LANES-1:0]                 issue_valid,
  input  tag_pkg::op_e [`LANES-1:0]         issue_op,
  input  logic [`LANES-1:0][`DATA_W-1:0]    issue_a,
  input  logic [`LANES-1:0][`DATA_W-1:0]    issue_b,
  input  logic [`LANES-1:0][`TAG_W-1:0]     issue_tag,
  output logic [`LANES-1:0]                 ex_valid,
  output logic [`LANES-1:0][`TAG_W-1:0]     ex_tag,
  output logic [`LANES-1:0][`DATA_W-1:0]    ex_value
);

  import tag_pkg::*;

  localparam int LN     = `LANES;
  localparam int STAGES = `EXEC_STAGES;

  logic [LN-1:0][`DATA_W-1:0]               alu;
  logic [STAGES-1:0][LN-1:0]                st_valid;
  logic [STAGES-1:0][LN-1:0][`TAG_W-1:0]    st_tag;
  logic [STAGES-1:0][LN-1:0][`DATA_W-1:0]   st_value;

  // wraps modulo 2^DATA_W
  always_comb begin
    for (int i = 0; i < LN; i++) begin
      case (issue_op[i])
        op_add:  alu[i] = issue_a[i] + issue_b[i];
        op_sub:  alu[i] = issue_a[i] - issue_b[i];
        op_and:  alu[i] = issue_a[i] & issue_b[i];
        op_xor:  alu[i] = issue_a[i] ^ issue_b[i];
        default: alu[i] = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      st_valid <= '0;
    end else begin
      st_valid[0] <= issue_valid;
      for (int s = 1; s < STAGES; s++) begin
        st_valid[s] <= st_valid[s-1];
      end
    end
  end

  // payload follows the valid bits
  always_ff @(posedge clk) begin
    st_tag[0]   <= issue_tag;
    st_value[0] <= alu;
    for (int s = 1; s < STAGES; s++) begin
      st_tag[s]   <= st_tag[s-1];
      st_value[s] <= st_value[s-1];
    end
  end

  assign ex_valid = st_valid[STAGES-1];
  assign ex_tag   = st_tag[STAGES-1];
  assign ex_value = st_value[STAGES-1];

  // freelist must never give one tag to both lanes of a group
  for (genvar s = 0; s < STAGES; s++) begin : g_chk
    a_tags_distinct : assert property (
      @(posedge clk) disable iff (rst || flush)
      (st_valid[s][0] && st_valid[s][1]) |-> (st_tag[s][0] != st_tag[s][1])
    ) else $error("op_execute: duplicate tag %0d in stage %0d", st_tag[s][0], s + 1);
  end

endmodule

`default_nettype wire

// ==== rtl/op_result.sv ====
// done outputs are registered and also feed tag return, flags come from the registered value
`timescale 1ns/1ps
`default_nettype none

`include "tag_settings.svh"

module op_result (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              flush,
  input  logic [`LANES-1:0]                 ex_valid,
  input  logic [`LANES-1:0][`TAG_W-1:0]     ex_tag,
  input  logic [`LANES-1:0][`DATA_W-1:0]    ex_value,
  output logic [`LANES-1:0]                 done_valid,
  output logic [`LANES-1:0][`TAG_W-1:0]     done_tag,
  output logic [`LANES-1:0][`DATA_W-1:0]    done_value,
  output logic [`LANES-1:0]                 done_zero,
  output logic [`LANES-1:0]                 done_neg
);

  localparam int LN = `LANES;
  localparam int DW = `DATA_W;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      done_valid <= '0;
    end else begin
      done_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    done_tag   <= ex_tag;
    done_value <= ex_value;
  end

  // flags per lane
  always_comb begin
    for (int i = 0; i < LN; i++) begin
      done_zero[i] = (done_value[i] == '0);
      done_neg[i]  = done_value[i][DW-1];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/tag_core.sv ====
// four-cycle fixed latency; hold in_insn while stall is high, flush drops every op in flight
`timescale 1ns/1ps
`default_nettype none

`include "tag_settings.svh"

module tag_core (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [`LANES-1:0]                 in_valid,
  input  logic [`LANES-1:0][`INSN_W-1:0]    in_insn,
  input  logic                              flush,
  output logic                              stall,
  output logic [`LANES-1:0]                 done_valid,
  output logic [`LANES-1:0][`TAG_W-1:0]     done_tag,
  output logic [`LANES-1:0][`DATA_W-1:0]    done_value,
  output logic [`LANES-1:0]                 done_zero,
  output logic [`LANES-1:0]                 done_neg
);

  import tag_pkg::*;

  // decode to freelist
  logic [`LANES-1:0]                 req;
  logic [`LANES-1:0][`TAG_W-1:0]     alloc_tag;

  // decode to execute
  logic [`LANES-1:0]                 issue_valid;
  op_e  [`LANES-1:0]                 issue_op;
  logic [`LANES-1:0][`DATA_W-1:0]    issue_a;
  logic [`LANES-1:0][`DATA_W-1:0]    issue_b;

  // execute to result
  logic [`LANES-1:0]                 ex_valid;
  logic [`LANES-1:0][`TAG_W-1:0]     ex_tag;
  logic [`LANES-1:0][`DATA_W-1:0]    ex_value;

  op_decode u_decode (
    .in_valid    (in_valid),
    .in_insn     (in_insn),
    .stall       (stall),
    .re          (req),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b)
  );

  // tag valid bits stay inside the freelist, stall already covers them
  // done outputs double as the tag return path
  freelist u_freelist (
    .clk   (clk),
    .rst   (rst),
    .flush (flush),
    .we    (done_valid),
    .wd    (done_tag),
    .re    (req),
    .rd    (alloc_tag),
    .v     (),
    .empty (stall)
  );

  op_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_tag   (alloc_tag),
    .ex_valid    (ex_valid),
    .ex_tag      (ex_tag),
    .ex_value    (ex_value)
  );

  op_result u_result (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .ex_valid   (ex_valid),
    .ex_tag     (ex_tag),
    .ex_value   (ex_value),
    .done_valid (done_valid),
    .done_tag   (done_tag),
    .done_value (done_value),
    .done_zero  (done_zero),
    .done_neg   (done_neg)
  );

endmodule

`default_nettype wire

// ==== rtl/tag_pkg.sv ====
// opcodes 4 to 6 are reserved; they take a tag and complete with value zero
`default_nettype none

`include "tag_settings.svh"

package tag_pkg;

  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_xor = 3'd3,
    // the only op that needs no tag
    op_nop = 3'd7
  } op_e;

  // register format with fmt 0
  typedef struct packed {
    op_e               opcode;
    logic              fmt;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
  } insn_reg_s;

  // immediate format with fmt 1
  // operand b is imm zero-extended and shifted left by shift within 8 bits
  typedef struct packed {
    op_e               opcode;
    logic              fmt;
    logic [`DATA_W-1:0] a;
    logic [1:0]        shift;
    logic [5:0]        imm;
  } insn_imm_s;

  // opcode and fmt sit at the same bits in both views
  typedef union packed {
    insn_reg_s as_reg;
    insn_imm_s as_imm;
  } insn_u;

endpackage

`default_nettype wire

// ==== rtl/tag_settings.svh ====
// sizes for the two-lane tag allocator; values assume LANES is 2 and TAG_COUNT a power of two
`ifndef TAG_SETTINGS_SVH
`define TAG_SETTINGS_SVH

// issue width, also freelist read and write width
`define LANES 2

// destination tags, TAG_W must equal log2 of TAG_COUNT
`define TAG_COUNT 8
`define TAG_W 3

// operand and result width
`define DATA_W 8

// instruction word, opcode + format bit + two operand fields
`define INSN_W 20

// execute pipeline depth, stage 1 holds the ALU result
`define EXEC_STAGES 3

`endif

// ==== tb.f ====
+incdir+rtl
rtl/tag_pkg.sv
rtl/freelist.sv
rtl/op_decode.sv
rtl/op_execute.sv
rtl/op_result.sv
rtl/tag_core.sv
bench/tag_core_tb.sv
